// File: sources.f
rtl/uart_pkg.sv
rtl/apb_pkg.sv
rtl/sync_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_apb_regs.sv
rtl/uart_apb_top.sv
verif/uart_apb_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = uart_apb_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/uart_apb_tb.sv
`timescale 1ns/1ps

module uart_apb_tb;
    import apb_pkg::*;

    localparam int CLK_FREQ    = 25_000_000;
    localparam int BAUD        = 1_000_000;
    localparam int FIFO_DEPTH  = 4;
    localparam int DIVIDER     = CLK_FREQ / BAUD;
    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ENTRIES = 12;
    localparam int FRAME_NS    = 10 * DIVIDER * CLK_PERIOD;
    localparam int WATCHDOG_NS = NUM_ENTRIES * 20 * FRAME_NS + 30 * FRAME_NS;

    localparam logic [7:0] FIXED_BYTES [4] = '{8'h00, 8'hff, 8'h55, 8'ha5};

    typedef struct packed {
        logic [7:0] din;
        logic [7:0] exp_data;
        logic [6:0] exp_status;
    } entry_t;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     txd;
    logic     rxd;
    logic     loopback;
    logic     bb_line;
    entry_t   stim_table [NUM_ENTRIES];

    assign rxd = loopback ? txd : bb_line;   // Line mux

    uart_apb_top #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD      (BAUD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut (
        .clk    (clk),
        .rst    (rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .txd    (txd),
        .rxd    (rxd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Status view from MSB to LSB
    function automatic logic [6:0] status_bits(input logic fe, input logic ov, input logic rf,
                                               input logic rv, input logic busy,
                                               input logic tf, input logic te);
        return {fe, ov, rf, rv, busy, tf, te};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Value mismatch in %s", what);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check({31'b0, apb_rsp.pready}, 32'd1, "pready in write access cycle");
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;   // Mid access cycle
        check({31'b0, apb_rsp.pready}, 32'd1, "pready in read access cycle");
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // Polls the TX status inside the DUT without an APB access
    task automatic wait_tx_idle();
        @(negedge clk);
        while (!dut.tx_status.empty || dut.tx_status.busy)
            @(negedge clk);
    endtask

    task automatic send_serial(input logic [7:0] data, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            bb_line = frame[i];
            repeat (DIVIDER - 1) @(posedge clk);
        end
        @(posedge clk);
        #1;
        bb_line = 1'b1;
    endtask

    initial begin
        logic [31:0] seed;
        logic [31:0] rd;
        uart_word_u  word;

        rst      = 1'b1;
        apb_req  = '0;
        loopback = 1'b1;
        bb_line  = 1'b1;

        seed = 32'hb797_bd8d;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (i < 4) begin
                stim_table[i].din = FIXED_BYTES[i];
            end else begin
                seed = xorshift32(seed);
                stim_table[i].din = seed[7:0];
            end
            stim_table[i].exp_data   = stim_table[i].din;
            // Byte received while the stop bit is still on the line
            stim_table[i].exp_status = status_bits(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        apb_read(REG_STATUS, rd);
        check(rd, {25'b0, status_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1)},
              "status after reset");
        check({31'b0, txd}, 32'd1, "txd idle after reset");

        // Loopback over the whole table
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apb_write(REG_DATA, {24'h0, stim_table[i].din});
            do begin
                apb_read(REG_STATUS, rd);
                word = rd;
            end while (!word.status.rx_valid);
            check(rd, {25'b0, stim_table[i].exp_status}, "status when byte arrives");
            apb_read(REG_DATA, rd);
            check(rd, {24'h0, stim_table[i].exp_data}, "loopback byte");
            apb_read(REG_STATUS, rd);
            word = rd;
            check({31'b0, word.status.rx_valid}, 32'd0, "rx fifo empty after read");
        end

        // Fill the RX FIFO and two more
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            wait_tx_idle();
            apb_write(REG_DATA, {24'h0, stim_table[i].din});
        end
        wait_tx_idle();
        apb_read(REG_STATUS, rd);
        check(rd, {25'b0, status_bits(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1)},
              "status after overrun");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            apb_read(REG_DATA, rd);
            check(rd, {24'h0, stim_table[i].exp_data}, "byte kept through overrun");
        end

        @(posedge clk);
        #1;
        loopback = 1'b0;
        send_serial(8'h3c, 1'b0);   // Bad stop bit
        apb_read(REG_STATUS, rd);
        check(rd, {25'b0, status_bits(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1)},
              "status after framing error");

        apb_read(REG_STATUS, rd);
        check(rd, {25'b0, status_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1)},
              "sticky bits cleared");

        apb_read(REG_DATA, rd);
        check(rd, 32'd0, "data read with rx fifo empty");
        apb_read(REG_STATUS, rd);
        check(rd, {25'b0, status_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1)},
              "status after empty data read");

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: rtl/uart_apb_top.sv
`timescale 1ns/1ps

module uart_apb_top #(
    parameter int CLK_FREQ   = 100_000_000,
    parameter int BAUD       = 115_200,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output logic              txd,
    input  logic              rxd
);
    import uart_pkg::*;

    logic       tx_push;
    logic [7:0] tx_byte;
    tx_status_t tx_status;
    logic       rx_pop;
    logic [7:0] rx_byte;
    rx_status_t rx_status;

    uart_apb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .tx_status(tx_status),
        .rx_pop   (rx_pop),
        .rx_byte  (rx_byte),
        .rx_status(rx_status)
    );

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD      (BAUD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .tx_status(tx_status),
        .txd      (txd)
    );

    uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD      (BAUD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .rx_pop   (rx_pop),
        .rx_byte  (rx_byte),
        .rx_status(rx_status)
    );

endmodule

// File: rtl/uart_apb_regs.sv
`timescale 1ns/1ps

module uart_apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t    apb_rsp,
    output logic                 tx_push,
    output logic [7:0]           tx_byte,
    input  uart_pkg::tx_status_t tx_status,
    output logic                 rx_pop,
    input  logic [7:0]           rx_byte,
    input  uart_pkg::rx_status_t rx_status
);
    import apb_pkg::*;

    logic       access;
    logic       rd_access;
    logic       wr_access;
    logic       sel_data;
    logic       sel_status;
    logic       clr_sticky;
    logic       overrun_q;
    logic       frame_err_q;
    uart_word_u wr_word;
    uart_word_u rd_word;

    assign access     = apb_req.psel && apb_req.penable;   // Access phase
    assign rd_access  = access && !apb_req.pwrite;
    assign wr_access  = access && apb_req.pwrite;
    assign sel_data   = (apb_req.paddr == REG_DATA);
    assign sel_status = (apb_req.paddr == REG_STATUS);

    assign wr_word = apb_req.pwdata;
    assign tx_push = wr_access && sel_data;     // Dropped inside the FIFO when full
    assign tx_byte = wr_word.data.value;

    assign rx_pop     = rd_access && sel_data && rx_status.valid;
    assign clr_sticky = rd_access && sel_status;

    always_comb begin
        rd_word = '0;
        if (rd_access) begin
            if (sel_data && rx_status.valid) begin
                rd_word.data.value = rx_byte;
            end else if (sel_status) begin
                rd_word.status.frame_err = frame_err_q;
                rd_word.status.overrun   = overrun_q;
                rd_word.status.rx_full   = rx_status.full;
                rd_word.status.rx_valid  = rx_status.valid;
                rd_word.status.tx_busy   = tx_status.busy;
                rd_word.status.tx_full   = tx_status.full;
                rd_word.status.tx_empty  = tx_status.empty;
            end
        end
    end

    // New pulses win over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (clr_sticky) begin
                overrun_q   <= 1'b0;
                frame_err_q <= 1'b0;
            end
            if (rx_status.overrun)
                overrun_q <= 1'b1;
            if (rx_status.frame_err)
                frame_err_q <= 1'b1;
        end
    end

    assign apb_rsp.prdata = rd_word;
    assign apb_rsp.pready = 1'b1;   // No wait states

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLK_FREQ   = 100_000_000,
    parameter int BAUD       = 115_200,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rxd,
    input  logic                 rx_pop,
    output logic [7:0]           rx_byte,
    output uart_pkg::rx_status_t rx_status
);
    import uart_pkg::*;

    localparam int DIVIDER = CLK_FREQ / BAUD;
    localparam int CNT_W   = $clog2(DIVIDER);

    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(DIVIDER / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LOAD  = CNT_W'(DIVIDER - 1);

    logic             rxd_meta;
    logic             rxd_s;
    logic             rxd_prev;
    logic [CNT_W-1:0] sample_cnt;
    logic             sample;
    logic [2:0]       bit_cnt;
    logic [7:0]       rx_shift;
    logic             stop_pt;
    logic             fifo_push;
    logic             fifo_empty;
    logic             fifo_full;
    rx_state_t        state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_prev <= rxd_s;     // Edge detect only
        end
    end

    assign sample = (sample_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RX_IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    // A line held low after a bad stop bit is not a new start
                    if (!rxd_s && rxd_prev) begin
                        sample_cnt <= HALF_LOAD;
                        state      <= RX_START;
                    end
                end
                RX_START: begin
                    if (!sample)
                        sample_cnt <= sample_cnt - 1'b1;
                    else if (!rxd_s) begin  // Start bit still low at mid-bit
                        bit_cnt    <= '0;
                        sample_cnt <= BIT_LOAD;
                        state      <= RX_DATA;
                    end else
                        state <= RX_IDLE;
                end
                RX_DATA: begin
                    if (!sample)
                        sample_cnt <= sample_cnt - 1'b1;
                    else begin
                        bit_cnt    <= bit_cnt + 1'b1;
                        sample_cnt <= BIT_LOAD;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (!sample)
                        sample_cnt <= sample_cnt - 1'b1;
                    else
                        state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample)
            rx_shift <= {rxd_s, rx_shift[7:1]};  // LSB arrives first
    end

    // Stop sample decides store, overrun or framing error
    assign stop_pt   = (state == RX_STOP) && sample;
    assign fifo_push = stop_pt && rxd_s && !fifo_full;

    sync_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk  (clk),
        .rst  (rst),
        .push (fifo_push),
        .pop  (rx_pop),
        .din  (rx_shift),
        .dout (rx_byte),
        .empty(fifo_empty),
        .full (fifo_full)
    );

    assign rx_status.valid     = !fifo_empty;
    assign rx_status.full      = fifo_full;
    assign rx_status.overrun   = stop_pt && rxd_s && fifo_full;
    assign rx_status.frame_err = stop_pt && !rxd_s;

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLK_FREQ   = 100_000_000,
    parameter int BAUD       = 115_200,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_push,
    input  logic [7:0]           tx_byte,
    output uart_pkg::tx_status_t tx_status,
    output logic                 txd
);
    import uart_pkg::*;

    localparam int DIVIDER = CLK_FREQ / BAUD;
    localparam int CNT_W   = $clog2(DIVIDER);

    logic [CNT_W-1:0] baud_cnt;
    logic             baud_tick;
    logic [7:0]       fifo_dout;
    logic             fifo_empty;
    logic             fifo_full;
    logic             fifo_pop;
    logic [7:0]       tx_hold;
    logic [9:0]       tx_shift;
    logic [3:0]       bit_cnt;
    logic             busy;
    tx_state_t        state;

    sync_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk  (clk),
        .rst  (rst),
        .push (tx_push),
        .pop  (fifo_pop),
        .din  (tx_byte),
        .dout (fifo_dout),
        .empty(fifo_empty),
        .full (fifo_full)
    );

    // Free running, one tick per bit period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baud_cnt  <= '0;
            baud_tick <= 1'b0;
        end else if (baud_cnt == CNT_W'(DIVIDER - 1)) begin
            baud_cnt  <= '0;
            baud_tick <= 1'b1;
        end else begin
            baud_cnt  <= baud_cnt + 1'b1;
            baud_tick <= 1'b0;
        end
    end

    assign fifo_pop = baud_tick && (state == TX_IDLE) && !fifo_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            busy    <= 1'b0;
            txd     <= 1'b1;
        end else if (baud_tick) begin
            case (state)
                TX_IDLE: begin
                    if (!fifo_empty) begin
                        busy  <= 1'b1;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    bit_cnt <= '0;
                    state   <= TX_SEND;
                end
                TX_SEND: begin
                    if (bit_cnt == 4'd10) begin    // Stop bit has had its full period
                        busy  <= 1'b0;
                        state <= TX_IDLE;
                    end else begin
                        txd     <= tx_shift[0];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop)
            tx_hold <= fifo_dout;
        if (baud_tick && state == TX_START)
            tx_shift <= {1'b1, tx_hold, 1'b0};   // Stop, data, start
        else if (baud_tick && state == TX_SEND)
            tx_shift <= {1'b1, tx_shift[9:1]};
    end

    assign tx_status.empty = fifo_empty;
    assign tx_status.full  = fifo_full;
    assign tx_status.busy  = busy;

endmodule

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign dout  = mem[rd_ptr];     // Head always visible

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

endmodule

// File: rtl/apb_pkg.sv
package apb_pkg;

    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_DATA   = 4'h0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

    typedef struct packed {
        logic [DATA_W-9:0] rsvd;
        logic [7:0]        value;
    } data_view_t;

    typedef struct packed {
        logic [DATA_W-8:0] rsvd;
        logic              frame_err;
        logic              overrun;
        logic              rx_full;
        logic              rx_valid;
        logic              tx_busy;
        logic              tx_full;
        logic              tx_empty;
    } status_view_t;

    typedef union packed {
        data_view_t   data;
        status_view_t status;
    } uart_word_u;

endpackage

// File: rtl/uart_pkg.sv
package uart_pkg;

    // Transmit path state as seen by the register block
    typedef struct packed {
        logic empty;
        logic full;
        logic busy;
    } tx_status_t;

    // Receive path state, error fields are single-cycle pulses
    typedef struct packed {
        logic valid;
        logic full;
        logic overrun;
        logic frame_err;
    } rx_status_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_SEND
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage
